//--- common/pw_pkg.sv
package pw_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and sizes

   localparam int NUM_TRIGGER_PULSES = 4;     // Pulses in one train
   localparam int TRIG_TIME_WIDTH    = 24;
   localparam int NUM_TRIGGER_WIDTH  = 4;
   localparam int BYTECNT_SIZE       = 7;
   localparam int FE_SELECT_WIDTH    = 2;
   localparam int PULSE_IDX_WIDTH    = $clog2(NUM_TRIGGER_PULSES);

   localparam int FIFO_DEPTH       = 16;
   localparam int FIFO_PTR_WIDTH   = $clog2(FIFO_DEPTH);
   localparam int FIFO_LEVEL_WIDTH = FIFO_PTR_WIDTH + 1;   // Holds 0..FIFO_DEPTH

   ////////////////////////////////////////////////////////////
   // Register map of the main page

   localparam logic [1:0] MAIN_REG_SELECT = 2'd0;   // Address bits 6:5

   localparam logic [4:0] REG_BUILDTIME            = 5'd0;
   localparam logic [4:0] REG_SNIFF_FIFO_STAT      = 5'd1;
   localparam logic [4:0] REG_SNIFF_FIFO_RD        = 5'd2;
   localparam logic [4:0] REG_FE_SELECT            = 5'd3;
   localparam logic [4:0] REG_ARM                  = 5'd4;
   localparam logic [4:0] REG_TRIGGER_ENABLE       = 5'd5;
   localparam logic [4:0] REG_TRIGGER_DELAY        = 5'd6;
   localparam logic [4:0] REG_TRIGGER_WIDTH        = 5'd7;
   localparam logic [4:0] REG_NUM_TRIGGERS         = 5'd8;
   localparam logic [4:0] REG_TRIG_CLK_PHASE_SHIFT = 5'd9;

   localparam logic [FE_SELECT_WIDTH-1:0] FE_USB = '0;

   // Byte 0 of the stamp is returned for bytecnt 0
   localparam logic [31:0] BUILD_STAMP = 32'h5A3C_0107;

   // Stream-empty marker
   localparam logic [1:0]  FE_FIFO_CMD_STRM   = 2'b10;
   localparam logic [15:0] FE_FIFO_STRM_EMPTY = 16'h0000;

   ////////////////////////////////////////////////////////////
   // Bundles

   typedef struct packed {
      logic [1:0]  cmd;
      logic [15:0] data;
   } fifo_word_t;

   typedef struct packed {
      logic                        overflow;
      logic [FIFO_LEVEL_WIDTH-1:0] level;
   } fifo_status_t;

   typedef struct packed {
      logic [7:0]              address;
      logic [BYTECNT_SIZE-1:0] bytecnt;
      logic [7:0]              write_data;
      logic                    read;
      logic                    write;
      logic                    addrvalid;
   } reg_bus_t;

   typedef struct packed {
      logic                                          enable;
      logic [NUM_TRIGGER_WIDTH-1:0]                  num_triggers;
      logic [NUM_TRIGGER_PULSES*TRIG_TIME_WIDTH-1:0] delay;   // Pulse 0 in low bits
      logic [NUM_TRIGGER_PULSES*TRIG_TIME_WIDTH-1:0] width;
   } trig_cfg_t;

endpackage

//--- compile.f
common/pw_pkg.sv
logic/cdc_pulse.sv
logic/sniff_fifo.sv
reg_main/reg_main.sv
trigger/trigger_gen.sv
logic/pw_top.sv
testbench/reg_main_props.sv
testbench/tb_pw.sv

//--- logic/cdc_pulse.sv
module cdc_pulse (
   input  logic reset_i,
   input  logic src_clk,
   input  logic src_pulse,
   input  logic dst_clk,
   output logic dst_pulse
);

   logic       src_toggle;
   logic [2:0] dst_sync;

   // Each source pulse flips the level
   always_ff @(posedge src_clk) begin
      if (reset_i)
         src_toggle <= 1'b0;
      else if (src_pulse)
         src_toggle <= ~src_toggle;
   end

   // Stages 0 and 1 resolve metastability, stage 2 is the edge reference
   always_ff @(posedge dst_clk) begin
      if (reset_i)
         dst_sync <= 3'b000;
      else
         dst_sync <= {dst_sync[1:0], src_toggle};
   end

   assign dst_pulse = dst_sync[2] ^ dst_sync[1];

endmodule

//--- logic/pw_top.sv
module pw_top
   import pw_pkg::*;
(
   input  logic                       cwusb_clk,
   input  logic                       fe_clk,
   input  logic                       reset_i,
   input  reg_bus_t                   bus,
   output logic [7:0]                 read_data,
   input  fifo_word_t                 sniff_word,
   input  logic                       sniff_valid,
   input  logic                       flushing,
   input  logic                       trig_in,
   output logic                       trig_out,
   output logic                       trig_busy,
   output logic                       psen,
   output logic                       psincdec,
   input  logic                       psdone,
   output logic [FE_SELECT_WIDTH-1:0] fe_select,
   output fifo_status_t               fifo_status
);

   fifo_word_t fifo_word;
   logic       fifo_empty;
   logic       fifo_read;
   logic       arm;
   trig_cfg_t  trig_cfg;
   logic       capture_pulse_fe;    // fe_clk domain
   logic       capture_pulse_usb;   // cwusb_clk domain

   reg_main u_reg_main (
      .cwusb_clk            (cwusb_clk),
      .reset_i              (reset_i),
      .bus                  (bus),
      .read_data            (read_data),
      .fifo_word            (fifo_word),
      .fifo_status          (fifo_status),
      .fifo_empty           (fifo_empty),
      .fifo_read            (fifo_read),
      .arm                  (arm),
      .reg_arm              (),
      .flushing             (flushing),
      .capture_enable_pulse (capture_pulse_usb),
      .trig_cfg             (trig_cfg),
      .psincdec             (psincdec),
      .psen                 (psen),
      .psdone               (psdone),
      .fe_select            (fe_select)
   );

   sniff_fifo u_sniff_fifo (
      .cwusb_clk (cwusb_clk),
      .reset_i   (reset_i),
      .push      (sniff_valid),
      .push_word (sniff_word),
      .pop       (fifo_read),
      .pop_word  (fifo_word),
      .empty     (fifo_empty),
      .status    (fifo_status)
   );

   cdc_pulse u_capture_cdc (
      .reset_i   (reset_i),
      .src_clk   (fe_clk),
      .src_pulse (capture_pulse_fe),
      .dst_clk   (cwusb_clk),
      .dst_pulse (capture_pulse_usb)
   );

   trigger_gen u_trigger_gen (
      .fe_clk               (fe_clk),
      .reset_i              (reset_i),
      .arm_level            (arm),
      .trig_cfg             (trig_cfg),
      .trig_in              (trig_in),
      .capture_enable_pulse (capture_pulse_fe),
      .trig_out             (trig_out),
      .trig_busy            (trig_busy)
   );

endmodule

//--- logic/sniff_fifo.sv
module sniff_fifo
   import pw_pkg::*;
(
   input  logic         cwusb_clk,
   input  logic         reset_i,
   input  logic         push,
   input  fifo_word_t   push_word,
   input  logic         pop,
   output fifo_word_t   pop_word,
   output logic         empty,
   output fifo_status_t status
);

   fifo_word_t                  mem [FIFO_DEPTH];
   logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
   logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
   logic [FIFO_LEVEL_WIDTH-1:0] level;
   logic                        overflow;
   logic                        full;
   logic                        do_push;
   logic                        do_pop;

   assign full    = (level == FIFO_LEVEL_WIDTH'(FIFO_DEPTH));
   assign empty   = (level == '0);
   assign do_push = push && !full;    // Full FIFO drops the word
   assign do_pop  = pop && !empty;

   assign status.overflow = overflow;
   assign status.level    = level;

   always_ff @(posedge cwusb_clk) begin
      if (do_push)
         mem[wr_ptr] <= push_word;
      if (do_pop)
         pop_word <= mem[rd_ptr];    // Registered output
   end

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         level    <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
         if (push && full)
            overflow <= 1'b1;         // Sticky until reset
      end
   end

endmodule

//--- reg_main/reg_main.sv
module reg_main
   import pw_pkg::*;
(
   input  logic                       cwusb_clk,
   input  logic                       reset_i,
   input  reg_bus_t                   bus,
   output logic [7:0]                 read_data,
   input  fifo_word_t                 fifo_word,
   input  fifo_status_t               fifo_status,
   input  logic                       fifo_empty,
   output logic                       fifo_read,
   output logic                       arm,
   output logic                       reg_arm,
   input  logic                       flushing,
   input  logic                       capture_enable_pulse,
   output trig_cfg_t                  trig_cfg,
   output logic                       psincdec,
   output logic                       psen,
   input  logic                       psdone,
   output logic [FE_SELECT_WIDTH-1:0] fe_select
);

   logic        selected;
   logic [4:0]  address;
   logic [1:0]  byte_sel;
   logic        reg_rd;
   logic        reg_wr;
   logic        fifo_rd_access;
   logic [7:0]  reg_read_data;
   logic        reg_arm_r;
   logic        phase_active;
   logic        fifo_empty_r;
   logic        empty_flag;
   fifo_word_t  fifo_out;

   assign selected       = bus.addrvalid && (bus.address[6:5] == MAIN_REG_SELECT);
   assign address        = bus.address[4:0];
   assign byte_sel       = bus.bytecnt[1:0];   // Byte within a FIFO entry
   assign reg_rd         = selected && bus.read;
   assign reg_wr         = selected && bus.write;
   assign fifo_rd_access = reg_rd && (address == REG_SNIFF_FIFO_RD);

   assign arm = reg_arm_r && !flushing;

   ////////////////////////////////////////////////////////////
   // Register reads, data valid one cycle after read

   always_ff @(posedge cwusb_clk) begin
      if (reg_rd) begin
         case (address)
            REG_BUILDTIME:            reg_read_data <= BUILD_STAMP[byte_sel*8 +: 8];
            REG_SNIFF_FIFO_STAT:      reg_read_data <= {2'b00, fifo_status};
            REG_FE_SELECT:            reg_read_data <= 8'(fe_select);
            REG_ARM:                  reg_read_data <= {7'b0, reg_arm};
            REG_TRIGGER_ENABLE:       reg_read_data <= {7'b0, trig_cfg.enable};
            REG_TRIGGER_DELAY:        reg_read_data <= trig_cfg.delay[bus.bytecnt*8 +: 8];
            REG_TRIGGER_WIDTH:        reg_read_data <= trig_cfg.width[bus.bytecnt*8 +: 8];
            REG_NUM_TRIGGERS:         reg_read_data <= 8'(trig_cfg.num_triggers);
            REG_TRIG_CLK_PHASE_SHIFT: reg_read_data <= {7'b0, phase_active};
            default:                  reg_read_data <= 8'h00;
         endcase
      end else begin
         reg_read_data <= 8'h00;
      end
   end

   ////////////////////////////////////////////////////////////
   // Sniff FIFO drain, four bytes per entry

   // Pop on byte 0 so the output register is loaded by the time it is sampled
   assign fifo_read = fifo_rd_access && (byte_sel == 2'd0) && !fifo_empty_r;

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         fifo_empty_r <= 1'b1;
         empty_flag   <= 1'b0;
      end else begin
         fifo_empty_r <= fifo_empty;
         if (fifo_rd_access && (byte_sel == 2'd0) && fifo_empty_r)
            empty_flag <= 1'b1;           // Nothing to pop, hand out the marker
         else if (fifo_rd_access && (byte_sel == 2'd3))
            empty_flag <= 1'b0;           // Byte 3 carries no data
      end
   end

   always_comb begin
      if (empty_flag)
         fifo_out = fifo_word_t'{cmd: FE_FIFO_CMD_STRM, data: FE_FIFO_STRM_EMPTY};
      else
         fifo_out = fifo_word;

      read_data = reg_read_data;
      if (selected && (address == REG_SNIFF_FIFO_RD)) begin
         case (byte_sel)
            2'd0:    read_data = fifo_out.data[7:0];
            2'd1:    read_data = fifo_out.data[15:8];
            2'd2:    read_data = {fifo_status, fifo_out.cmd};
            default: read_data = 8'h00;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Register writes

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         fe_select             <= FE_USB;
         reg_arm               <= 1'b0;
         reg_arm_r             <= 1'b0;
         trig_cfg.enable       <= 1'b0;
         trig_cfg.num_triggers <= NUM_TRIGGER_WIDTH'(1);
         trig_cfg.delay        <= '0;
         trig_cfg.width        <= '0;
         psen                  <= 1'b0;
         psincdec              <= 1'b0;
         phase_active          <= 1'b0;
      end else begin
         reg_arm_r <= reg_arm;   // arm_level trails reg_arm by one cycle

         if (reg_wr) begin
            case (address)
               REG_FE_SELECT:      fe_select <= bus.write_data[FE_SELECT_WIDTH-1:0];
               REG_TRIGGER_ENABLE: trig_cfg.enable <= bus.write_data[0];
               REG_TRIGGER_DELAY:  trig_cfg.delay[bus.bytecnt*8 +: 8] <= bus.write_data;
               REG_TRIGGER_WIDTH:  trig_cfg.width[bus.bytecnt*8 +: 8] <= bus.write_data;
               REG_NUM_TRIGGERS:
                  trig_cfg.num_triggers <= bus.write_data[NUM_TRIGGER_WIDTH-1:0];
               default: ;
            endcase
         end

         // Arm clears itself once the capture has started
         if (reg_wr && (address == REG_ARM))
            reg_arm <= bus.write_data[0];
         else if (capture_enable_pulse)
            reg_arm <= 1'b0;

         // One step per request, further requests wait for psdone
         if (reg_wr && (address == REG_TRIG_CLK_PHASE_SHIFT) && !phase_active) begin
            psincdec     <= bus.write_data[0];
            psen         <= 1'b1;
            phase_active <= 1'b1;
         end else begin
            psen <= 1'b0;
            if (psdone)
               phase_active <= 1'b0;
         end
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
   --top-module tb_pw \
   -f compile.f \
   -o tb_pw &&
./obj_dir/tb_pw ||
exit 1

//--- testbench/reg_main_props.sv
module reg_main_props (
   input logic cwusb_clk,
   input logic reset_i,
   input logic psen,
   input logic psdone,
   input logic fifo_read,
   input logic fifo_empty
);

   logic step_open;   // Phase step issued, psdone not yet seen

   always_ff @(posedge cwusb_clk) begin
      if (reset_i)
         step_open <= 1'b0;
      else if (psen)
         step_open <= 1'b1;
      else if (psdone)
         step_open <= 1'b0;
   end

   // Phase step strobe is one cycle wide
   psen_single: assert property (@(posedge cwusb_clk) disable iff (reset_i)
      psen |=> !psen)
      else $error("psen stayed high for more than one cycle");

   no_pop_when_empty: assert property (@(posedge cwusb_clk) disable iff (reset_i)
      fifo_read |-> !$past(fifo_empty))
      else $error("FIFO pop issued while the registered empty flag was set");

   // A new step only starts once the previous one is done
   psen_when_idle: assert property (@(posedge cwusb_clk) disable iff (reset_i)
      psen |-> !step_open)
      else $error("psen fired while a phase step was still active");

endmodule

bind reg_main reg_main_props u_reg_main_props (
   .cwusb_clk  (cwusb_clk),
   .reset_i    (reset_i),
   .psen       (psen),
   .psdone     (psdone),
   .fifo_read  (fifo_read),
   .fifo_empty (fifo_empty)
);

//--- testbench/tb_pw.sv
module tb_pw
   import pw_pkg::*;
();

   localparam int WATCHDOG_CYCLES = 20000;   // The tests need well under 1000 cycles
   localparam int TIME_BYTES      = TRIG_TIME_WIDTH / 8;

   logic                       cwusb_clk = 1'b0;
   logic                       fe_clk    = 1'b0;
   logic                       reset_i;
   reg_bus_t                   bus;
   logic [7:0]                 read_data;
   fifo_word_t                 sniff_word;
   logic                       sniff_valid;
   logic                       flushing;
   logic                       trig_in;
   logic                       trig_out;
   logic                       trig_busy;
   logic                       psen;
   logic                       psincdec;
   logic                       psdone;
   logic [FE_SELECT_WIDTH-1:0] fe_select;
   fifo_status_t               fifo_status;
   logic [31:0]                lfsr_state = 32'h71143787;
   int                         psen_count = 0;
   logic                       psen_dir   = 1'b0;

   always #20 cwusb_clk = ~cwusb_clk;
   always #15 fe_clk    = ~fe_clk;

   pw_top u_dut (.*);

   // Phase-step strobes seen at the top
   always @(negedge cwusb_clk) begin
      if (!reset_i && psen) begin
         psen_count = psen_count + 1;
         psen_dir   = psincdec;
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers

   task automatic report_failure(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      assert (got === exp)
      else report_failure($sformatf("%s read %h, expected %h", what, got, exp));
   endtask

   // Galois LFSR, taps 32 30 26 25
   function automatic logic [31:0] random_bits(input int nbits);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   task automatic bus_write(input logic [4:0] reg_addr, input int bc, input logic [7:0] data);
      @(posedge cwusb_clk);
      bus.address    <= {1'b0, MAIN_REG_SELECT, reg_addr};
      bus.bytecnt    <= BYTECNT_SIZE'(bc);
      bus.write_data <= data;
      bus.addrvalid  <= 1'b1;
      bus.write      <= 1'b1;
      @(posedge cwusb_clk);
      bus.write <= 1'b0;
   endtask

   task automatic bus_read(input logic [7:0] addr, input int bc, output logic [7:0] data);
      @(posedge cwusb_clk);
      bus.address   <= addr;
      bus.bytecnt   <= BYTECNT_SIZE'(bc);
      bus.addrvalid <= 1'b1;
      bus.read      <= 1'b1;
      @(posedge cwusb_clk);
      bus.read <= 1'b0;
      @(negedge cwusb_clk);   // Register and FIFO bytes both settled
      data = read_data;
   endtask

   task automatic read_expect(input logic [4:0] reg_addr, input int bc,
                              input logic [7:0] exp, input string what);
      logic [7:0] data;
      bus_read({1'b0, MAIN_REG_SELECT, reg_addr}, bc, data);
      check_byte(data, exp, $sformatf("%s byte %0d", what, bc));
   endtask

   // One delay or width field, low byte first
   task automatic write_time_field(input logic [4:0] reg_addr, input int pulse,
                                   input logic [TRIG_TIME_WIDTH-1:0] value);
      for (int i = 0; i < TIME_BYTES; i++)
         bus_write(reg_addr, TIME_BYTES * pulse + i, value[8*i +: 8]);
   endtask

   task automatic push_sniff_word(input fifo_word_t w);
      @(posedge cwusb_clk);
      sniff_word  <= w;
      sniff_valid <= 1'b1;
      @(posedge cwusb_clk);
      sniff_valid <= 1'b0;
   endtask

   task automatic read_fifo_entry(input fifo_word_t exp, input int level, input string what);
      read_expect(REG_SNIFF_FIFO_RD, 0, exp.data[7:0], what);
      read_expect(REG_SNIFF_FIFO_RD, 1, exp.data[15:8], what);
      read_expect(REG_SNIFF_FIFO_RD, 2, {1'b0, FIFO_LEVEL_WIDTH'(level), exp.cmd}, what);
      read_expect(REG_SNIFF_FIFO_RD, 3, 8'h00, what);
   endtask

   // Counts fe_clk cycles while trig_out stays at level
   task automatic measure_run(input logic level, output int len);
      len = 0;
      while (trig_busy && (trig_out == level)) begin
         len++;
         @(negedge fe_clk);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests

   task automatic check_reset_values();
      logic [7:0] data;
      for (int i = 0; i < 4; i++)
         read_expect(REG_BUILDTIME, i, BUILD_STAMP[8*i +: 8], "build stamp");
      read_expect(REG_SNIFF_FIFO_STAT, 0, 8'h00, "fifo status");
      read_expect(REG_FE_SELECT, 0, 8'h00, "fe_select");
      read_expect(REG_ARM, 0, 8'h00, "arm");
      read_expect(REG_TRIGGER_ENABLE, 0, 8'h00, "trigger enable");
      read_expect(REG_NUM_TRIGGERS, 0, 8'h01, "num triggers");
      read_expect(REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h00, "phase shift");
      for (int i = 0; i < TIME_BYTES * NUM_TRIGGER_PULSES; i++) begin
         read_expect(REG_TRIGGER_DELAY, i, 8'h00, "delay");
         read_expect(REG_TRIGGER_WIDTH, i, 8'h00, "width");
      end
      assert (!psen && !psincdec && !trig_out && !trig_busy && (fifo_status == '0))
      else report_failure("an output is active after reset");
      bus_read({1'b0, MAIN_REG_SELECT ^ 2'b01, REG_BUILDTIME}, 0, data);   // Other page
      check_byte(data, 8'h00, "unselected page");
      bus_write(REG_FE_SELECT, 0, 8'h02);
      read_expect(REG_FE_SELECT, 0, 8'h02, "fe_select");
      assert (fe_select == FE_SELECT_WIDTH'(2))
      else report_failure($sformatf("fe_select port is %0d, expected 2", fe_select));
   endtask

   task automatic check_trigger_config();
      logic [31:0]                rnd;
      logic [TRIG_TIME_WIDTH-1:0] delays [NUM_TRIGGER_PULSES];
      logic [TRIG_TIME_WIDTH-1:0] widths [NUM_TRIGGER_PULSES];
      logic [7:0]                 num;
      for (int p = 0; p < NUM_TRIGGER_PULSES; p++) begin
         rnd       = random_bits(TRIG_TIME_WIDTH);
         delays[p] = rnd[TRIG_TIME_WIDTH-1:0];
         rnd       = random_bits(TRIG_TIME_WIDTH);
         widths[p] = rnd[TRIG_TIME_WIDTH-1:0];
         write_time_field(REG_TRIGGER_DELAY, p, delays[p]);
         write_time_field(REG_TRIGGER_WIDTH, p, widths[p]);
      end
      rnd = random_bits(NUM_TRIGGER_WIDTH);
      num = 8'(rnd[NUM_TRIGGER_WIDTH-1:0]);
      bus_write(REG_NUM_TRIGGERS, 0, num);
      bus_write(REG_TRIGGER_ENABLE, 0, 8'h01);
      for (int p = 0; p < NUM_TRIGGER_PULSES; p++) begin
         for (int i = 0; i < TIME_BYTES; i++) begin
            read_expect(REG_TRIGGER_DELAY, TIME_BYTES * p + i, delays[p][8*i +: 8], "delay");
            read_expect(REG_TRIGGER_WIDTH, TIME_BYTES * p + i, widths[p][8*i +: 8], "width");
         end
      end
      read_expect(REG_NUM_TRIGGERS, 0, num, "num triggers");
      read_expect(REG_TRIGGER_ENABLE, 0, 8'h01, "trigger enable");
   endtask

   task automatic run_trigger_train();
      logic [TRIG_TIME_WIDTH-1:0] dly [2];
      logic [TRIG_TIME_WIDTH-1:0] wid [2];
      int                         len;
      dly[0] = 24'd5;
      wid[0] = 24'd3;
      dly[1] = 24'd4;
      wid[1] = 24'd6;
      for (int p = 0; p < 2; p++) begin
         write_time_field(REG_TRIGGER_DELAY, p, dly[p]);
         write_time_field(REG_TRIGGER_WIDTH, p, wid[p]);
      end
      bus_write(REG_NUM_TRIGGERS, 0, 8'h02);
      bus_write(REG_TRIGGER_ENABLE, 0, 8'h01);
      bus_write(REG_ARM, 0, 8'h01);
      read_expect(REG_ARM, 0, 8'h01, "arm");
      repeat (3) @(posedge fe_clk);   // Two-stage arm synchronizer
      trig_in <= 1'b1;
      do @(negedge fe_clk); while (!trig_busy);
      for (int p = 0; p < 2; p++) begin
         measure_run(1'b0, len);
         assert (len == int'(dly[p]))
         else report_failure($sformatf("pulse %0d low for %0d cycles, expected %0d",
                                       p, len, dly[p]));
         measure_run(1'b1, len);
         assert (len == int'(wid[p]))
         else report_failure($sformatf("pulse %0d high for %0d cycles, expected %0d",
                                       p, len, wid[p]));
      end
      assert (!trig_busy) else report_failure("trigger train did not end after two pulses");
      @(posedge fe_clk);
      trig_in <= 1'b0;
      read_expect(REG_ARM, 0, 8'h00, "arm after capture");

      // Flushing keeps the trigger side disarmed
      @(posedge cwusb_clk);
      flushing <= 1'b1;
      bus_write(REG_ARM, 0, 8'h01);
      repeat (3) @(posedge fe_clk);
      trig_in <= 1'b1;
      repeat (40) begin
         @(negedge fe_clk);
         assert (!trig_busy) else report_failure("trigger train started while flushing");
      end
      read_expect(REG_ARM, 0, 8'h01, "arm while flushing");
      bus_write(REG_ARM, 0, 8'h00);
      @(posedge cwusb_clk);
      flushing <= 1'b0;
      @(posedge fe_clk);
      trig_in <= 1'b0;
   endtask

   task automatic drain_sniff_fifo();
      fifo_word_t  words [$];
      fifo_word_t  w;
      fifo_word_t  marker;
      logic [31:0] rnd;
      for (int i = 0; i < 5; i++) begin
         rnd = random_bits(18);
         w   = fifo_word_t'(rnd[17:0]);
         words.push_back(w);
         push_sniff_word(w);
      end
      read_expect(REG_SNIFF_FIFO_STAT, 0, 8'(words.size()), "fifo level");
      assert (!fifo_status.overflow && (fifo_status.level == FIFO_LEVEL_WIDTH'(words.size())))
      else report_failure($sformatf("fifo_status port is %h, expected level %0d",
                                    fifo_status, words.size()));
      while (words.size() > 0) begin
         w = words.pop_front();
         read_fifo_entry(w, words.size(), "fifo entry");
      end
      marker.cmd  = FE_FIFO_CMD_STRM;
      marker.data = FE_FIFO_STRM_EMPTY;
      read_fifo_entry(marker, 0, "empty marker");
      for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
         rnd = random_bits(18);
         push_sniff_word(fifo_word_t'(rnd[17:0]));
      end
      read_expect(REG_SNIFF_FIFO_STAT, 0, {2'b00, 1'b1, FIFO_LEVEL_WIDTH'(FIFO_DEPTH)},
                  "fifo overflow");
      assert (fifo_status.overflow && (fifo_status.level == FIFO_LEVEL_WIDTH'(FIFO_DEPTH)))
      else report_failure($sformatf("fifo_status port is %h after overflow", fifo_status));
   endtask

   task automatic step_trigger_phase();
      bus_write(REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h01);
      repeat (2) @(negedge cwusb_clk);
      assert (psen_count == 1 && psen_dir == 1'b1)
      else report_failure($sformatf("%0d psen pulses, psincdec %b", psen_count, psen_dir));
      bus_write(REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h00);   // Still waiting for psdone
      repeat (2) @(negedge cwusb_clk);
      assert (psen_count == 1 && psincdec)
      else report_failure("phase shift request accepted while busy");
      read_expect(REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h01, "phase shift busy");
      @(posedge cwusb_clk);
      psdone <= 1'b1;
      @(posedge cwusb_clk);
      psdone <= 1'b0;
      read_expect(REG_TRIG_CLK_PHASE_SHIFT, 0, 8'h00, "phase shift done");
   endtask

   ////////////////////////////////////////////////////////////
   // Sequence and watchdog

   initial begin
      reset_i     <= 1'b1;
      bus         <= '0;
      sniff_word  <= '0;
      sniff_valid <= 1'b0;
      flushing    <= 1'b0;
      trig_in     <= 1'b0;
      psdone      <= 1'b0;
      repeat (4) @(posedge cwusb_clk);
      reset_i <= 1'b0;
      check_reset_values();
      check_trigger_config();
      run_trigger_train();
      drain_sniff_fifo();
      step_trigger_phase();
      $display("Test OK");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge cwusb_clk);
      $display("Timeout: tests did not finish within %0d cwusb_clk cycles", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- trigger/trigger_gen.sv
module trigger_gen
   import pw_pkg::*;
(
   input  logic      fe_clk,
   input  logic      reset_i,
   input  logic      arm_level,
   input  trig_cfg_t trig_cfg,
   input  logic      trig_in,
   output logic      capture_enable_pulse,
   output logic      trig_out,
   output logic      trig_busy
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_DELAY,
      S_HIGH
   } state_t;

   state_t                     state;
   logic [1:0]                 arm_sync;
   logic                       armed;
   logic                       fired;
   logic                       trig_in_r;
   logic                       trig_edge;
   logic [PULSE_IDX_WIDTH-1:0] pulse_idx;
   logic [PULSE_IDX_WIDTH-1:0] next_idx;
   logic [TRIG_TIME_WIDTH-1:0] count;
   logic [TRIG_TIME_WIDTH-1:0] cur_width;
   logic [TRIG_TIME_WIDTH-1:0] next_delay;
   logic                       last_pulse;

   assign armed      = arm_sync[1];
   assign trig_edge  = trig_in && !trig_in_r;
   assign next_idx   = pulse_idx + 1'b1;
   assign cur_width  = trig_cfg.width[pulse_idx*TRIG_TIME_WIDTH +: TRIG_TIME_WIDTH];
   assign next_delay = trig_cfg.delay[next_idx*TRIG_TIME_WIDTH +: TRIG_TIME_WIDTH];

   // Train ends at num_triggers or at the last slot
   assign last_pulse = (pulse_idx == PULSE_IDX_WIDTH'(NUM_TRIGGER_PULSES - 1)) ||
                       (NUM_TRIGGER_WIDTH'(pulse_idx) + 1'b1 >= trig_cfg.num_triggers);

   assign trig_out  = (state == S_HIGH);
   assign trig_busy = (state != S_IDLE);

   ////////////////////////////////////////////////////////////
   // Arm sync, edge detect and pulse train

   // Low phase starts together with capture_enable_pulse; a zero delay
   // still gives one low cycle
   always_ff @(posedge fe_clk) begin
      if (reset_i) begin
         arm_sync             <= 2'b00;
         trig_in_r            <= 1'b0;
         fired                <= 1'b0;
         capture_enable_pulse <= 1'b0;
         pulse_idx            <= '0;
         state                <= S_IDLE;
      end else begin
         arm_sync             <= {arm_sync[0], arm_level};
         trig_in_r            <= trig_in;
         capture_enable_pulse <= 1'b0;
         if (!armed)
            fired <= 1'b0;          // Next arm allows a new capture

         case (state)
            S_IDLE: begin
               if (trig_edge && armed && !fired) begin
                  capture_enable_pulse <= 1'b1;
                  fired                <= 1'b1;
                  pulse_idx            <= '0;
                  count                <= trig_cfg.delay[TRIG_TIME_WIDTH-1:0];
                  if (trig_cfg.enable && (trig_cfg.num_triggers != '0))
                     state <= S_DELAY;
               end
            end
            S_DELAY: begin
               if (count > TRIG_TIME_WIDTH'(1)) begin
                  count <= count - 1'b1;
               end else if (cur_width != '0) begin
                  count <= cur_width;
                  state <= S_HIGH;
               end else if (last_pulse) begin
                  state <= S_IDLE;
               end else begin
                  pulse_idx <= next_idx;      // Zero width skips the pulse
                  count     <= next_delay;
               end
            end
            S_HIGH: begin
               if (count > TRIG_TIME_WIDTH'(1)) begin
                  count <= count - 1'b1;
               end else if (last_pulse) begin
                  state <= S_IDLE;
               end else begin
                  pulse_idx <= next_idx;
                  count     <= next_delay;
                  state     <= S_DELAY;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule
